// File: cam_frame_dma.f
+incdir+verification
src/cam_pix_pkg.sv
src/cam_ctrl_pkg.sv
src/cam_capture_ctrl.sv
src/cam_pixel_lane.sv
src/cam_sync_fifo.sv
src/cam_dma_writer.sv
src/cam_frame_dma_top.sv
verification/tb_cam_frame_dma.sv

// File: verification/tb_cam_frame_dma_ref.svh
////////////////////////////////////////////////////////////////////////////
// Reference model helpers for the frame DMA testbench. Expects the
// including module to declare err_count and check_count. Pixel words
// follow the packing of pixel 0 in bits 23:0 and pixel 1 in bits 55:32.
////////////////////////////////////////////////////////////////////////////

`ifndef TB_CAM_FRAME_DMA_REF_SVH
`define TB_CAM_FRAME_DMA_REF_SVH

// Linear congruential generator step
function automatic logic [31:0] lcg_next(input logic [31:0] s);
   return s * 32'd1664525 + 32'd1013904223;
endfunction

// Weighted gray level, weights sum to 256
function automatic logic [7:0] gray_level(input logic [7:0] r, g, b);
   int sum;
   sum = 77 * int'(r) + 150 * int'(g) + 29 * int'(b);
   return 8'(sum >> 8);
endfunction

// Expected DMA word for one pixel pair
function automatic logic [63:0] ref_word(input logic [15:0] r, g, b, input logic gray);
   logic [7:0]  y0, y1;
   logic [23:0] p0, p1;
   y0 = gray_level(r[7:0], g[7:0], b[7:0]);
   y1 = gray_level(r[15:8], g[15:8], b[15:8]);
   p0 = gray ? {y0, y0, y0} : {b[7:0], g[7:0], r[7:0]};
   p1 = gray ? {y1, y1, y1} : {b[15:8], g[15:8], r[15:8]};
   return {8'h00, p1, 8'h00, p0};
endfunction

task automatic check_value(input logic [63:0] got, exp, input string what);
   check_count++;
   if (got !== exp) begin
      err_count++;
      $display("mismatch at %0d ns: %s got %h expected %h", $time, what, got, exp);
   end
endtask

`endif

// File: verification/tb_cam_frame_dma.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the frame DMA path with bursts of 8, a 16 word FIFO and a
// 3001 cycle fps window. Frames are 4 lines of 4 pixel pairs. Capture
// state is tracked by the test sequence, so tests run in a fixed order
// and continuous capture stays on from test 3 onwards.
////////////////////////////////////////////////////////////////////////////

module tb_cam_frame_dma;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int BURST     = 8;
   localparam int DEPTH     = 16;
   localparam int RATE      = 3000;
   localparam int FRAME_CYC = 6 + 4 + 4 * 6;
   localparam int WD_CYCLES = 6 * FRAME_CYC * 20 + 3 * (RATE + 1);

   logic        mipi_pclk = 1'b0;
   logic        rst_n, cam_vs_i, cam_valid_i;
   logic [15:0] cam_r_i, cam_g_i, cam_b_i;
   logic        trigger_capture_i, continuous_capture_i, rgb_gray_i;
   logic        dma_init_done_i, dma_wready_i;
   logic        dma_wvalid_o, dma_wlast_o, dbg_fifo_overflow_o;
   logic [63:0] dma_wdata_o;
   logic [31:0] frames_per_second_o, dbg_fifo_wcount_o, dbg_fifo_rcount_o;

   int          err_count = 0;
   int          check_count = 0;
   logic [63:0] exp_q[$];
   logic [63:0] exp_w;
   logic [31:0] lcg_state = 32'h5ed96e03;
   logic [31:0] bp_state = 32'h5ed96e03;
   int          beat_cnt = 0;
   int          xfer_cnt = 0;
   bit          init_req = 0;
   bit          bp_mode = 0;
   bit          wready_lvl = 1;
   // fps model state
   int          tmr, win_cnt, exp_fps, wraps = 0;
   bit          vs_d1, vs_d2, fps_pend = 0;

   `include "tb_cam_frame_dma_ref.svh"

   cam_frame_dma_top #(
      .PIX_PER_CLK         (2),
      .FIFO_DEPTH          (DEPTH),
      .DMA_TRANSFER_LENGTH (BURST),
      .PCLK_RATE           (RATE)
   ) i_dut (.*);

   always #5 mipi_pclk = ~mipi_pclk;

   task automatic drive_frame(input int lines, input bit capture, input bit trig);
      logic [31:0] a, b;
      for (int i = 0; i < 6; i++) begin
         @(posedge mipi_pclk);
         cam_vs_i          <= 1'b1;
         cam_valid_i       <= 1'b0;
         trigger_capture_i <= trig && (i < 2);
      end
      repeat (4) begin
         @(posedge mipi_pclk);
         cam_vs_i <= 1'b0;
      end
      repeat (lines) begin
         repeat (4) begin
            @(posedge mipi_pclk);
            lcg_state = lcg_next(lcg_state);
            a = lcg_state;
            lcg_state = lcg_next(lcg_state);
            b = lcg_state;
            cam_valid_i <= 1'b1;
            cam_r_i     <= a[15:0];
            cam_g_i     <= a[31:16];
            cam_b_i     <= b[15:0];
            if (capture) exp_q.push_back(ref_word(a[15:0], a[31:16], b[15:0], rgb_gray_i));
         end
         repeat (2) begin
            @(posedge mipi_pclk);
            cam_valid_i <= 1'b0;
         end
      end
   endtask

   task automatic wait_drain;
      while (exp_q.size() != 0) @(negedge mipi_pclk);
      @(posedge mipi_pclk);
      @(negedge mipi_pclk);
   endtask

   task automatic report_test(input int n, input string name, input int e0);
      $display("test %0d %s: %s", n, name, (err_count == e0) ? "ok" : "errors seen");
   endtask

   // Init done pulse and ready source
   always @(posedge mipi_pclk) begin
      dma_init_done_i <= init_req;
      init_req = 0;
      bp_state = lcg_next(bp_state);
      dma_wready_i <= bp_mode ? bp_state[16] : wready_lvl;
   end

   // Compare process, sees each transfer before its clock edge
   always @(negedge mipi_pclk) begin
      if (rst_n && dma_wvalid_o && dma_wready_i) begin
         if (exp_q.size() == 0) begin
            err_count++;
            $display("error at %0d ns: DMA transfer with no expected word", $time);
         end else begin
            exp_w = exp_q.pop_front();
            check_value(dma_wdata_o, exp_w, "wdata");
         end
         check_value(64'(dma_wlast_o), 64'(beat_cnt % BURST == BURST - 1), "wlast");
         if (dma_wlast_o) init_req = 1;
         beat_cnt++;
         xfer_cnt++;
      end
      if (fps_pend) begin
         check_value(64'(frames_per_second_o), 64'(exp_fps), "frames per second");
         fps_pend = 0;
         wraps++;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Frame rate reference, falling vsync counted two edges after it is driven
   ////////////////////////////////////////////////////////////////////////////

   always @(posedge mipi_pclk) begin
      if (!rst_n) begin
         tmr     = 0;
         win_cnt = 0;
         exp_fps = 0;
         vs_d1   = 0;
         vs_d2   = 0;
      end else begin
         if (tmr == RATE) begin
            exp_fps  = win_cnt;
            win_cnt  = 0;
            tmr      = 0;
            fps_pend = 1;
         end else begin
            tmr++;
            if (vs_d2 && !vs_d1) win_cnt++;
         end
         vs_d2 = vs_d1;
         vs_d1 = cam_vs_i;
      end
   end

   initial begin
      repeat (WD_CYCLES) @(posedge mipi_pclk);
      $display("timeout: the tests did not finish within %0d cycles", WD_CYCLES);
      $display("TEST FAILED");
      $finish;
   end

   initial begin
      int e0;
      logic [31:0] cnt0;
      rst_n = 1'b0;
      cam_vs_i = 1'b0;
      cam_valid_i = 1'b0;
      cam_r_i = '0;
      cam_g_i = '0;
      cam_b_i = '0;
      trigger_capture_i = 1'b0;
      continuous_capture_i = 1'b0;
      rgb_gray_i = 1'b0;
      dma_init_done_i = 1'b0;
      dma_wready_i = 1'b0;
      repeat (16) @(posedge mipi_pclk);
      rst_n <= 1'b1;
      init_req = 1;

      // 1: only the triggered frame is written
      e0 = err_count;
      cnt0 = dbg_fifo_wcount_o;
      drive_frame(4, 0, 0);
      drive_frame(4, 1, 1);
      drive_frame(4, 0, 0);
      repeat (4) @(posedge mipi_pclk);
      check_value(64'(dbg_fifo_wcount_o - cnt0), 64'd16, "write count");
      wait_drain();
      report_test(1, "single trigger", e0);

      // 2: gray frame
      e0 = err_count;
      @(posedge mipi_pclk);
      rgb_gray_i <= 1'b1;
      drive_frame(4, 1, 1);
      @(posedge mipi_pclk);
      rgb_gray_i <= 1'b0;
      wait_drain();
      report_test(2, "grayscale", e0);

      // 3: continuous capture, the frame left open by test 2 closes first
      e0 = err_count;
      @(posedge mipi_pclk);
      continuous_capture_i <= 1'b1;
      drive_frame(4, 0, 0);
      repeat (2) drive_frame(4, 1, 0);
      wait_drain();
      report_test(3, "continuous capture", e0);

      // 4: random back-pressure
      e0 = err_count;
      bp_mode = 1;
      repeat (2) drive_frame(4, 1, 0);
      wait_drain();
      bp_mode = 0;
      check_value(64'(dbg_fifo_rcount_o), 64'(xfer_cnt), "read count");
      report_test(4, "back-pressure", e0);

      // 5: two frames into a stalled FIFO
      e0 = err_count;
      wready_lvl = 0;
      cnt0 = dbg_fifo_rcount_o;
      repeat (2) drive_frame(4, 1, 0);
      repeat (4) @(posedge mipi_pclk);
      check_value(64'(dbg_fifo_overflow_o), 64'd1, "sticky overflow");
      wready_lvl = 1;
      while (dbg_fifo_rcount_o != cnt0 + DEPTH) @(negedge mipi_pclk);
      repeat (20) @(negedge mipi_pclk);
      check_value(64'(dbg_fifo_rcount_o - cnt0), 64'(DEPTH), "words delivered");
      check_value(64'(exp_q.size()), 64'(DEPTH), "words lost");
      exp_q.delete();
      report_test(5, "overflow", e0);

      // 6: vsync only frames until three fps windows have closed
      e0 = err_count;
      while (wraps < 3) drive_frame(0, 1, 0);
      repeat (2) @(negedge mipi_pclk);
      report_test(6, "frames per second", e0);

      $display("checks %0d, errors %0d", check_count, err_count);
      if (err_count == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule : tb_cam_frame_dma

// File: src/cam_frame_dma_top.sv
////////////////////////////////////////////////////////////////////////////
// Camera frame capture path into a DMA stream. Input is RGB at two pixels
// per clock with pixel 0 in the low byte of each channel. A pixel pair
// sampled with capture active reaches the FIFO two clocks later.
// PCLK_RATE must match mipi_pclk for the fps output to be meaningful.
////////////////////////////////////////////////////////////////////////////

module cam_frame_dma_top
   import cam_pix_pkg::*;
   import cam_ctrl_pkg::*;
#(
   parameter int PIX_PER_CLK         = 2,
   parameter int FIFO_DEPTH          = 512,
   parameter int DMA_TRANSFER_LENGTH = 1920,
   parameter int PCLK_RATE           = 75000000
) (
   input  logic                         mipi_pclk,
   input  logic                         rst_n,
   input  logic                         cam_vs_i,
   input  logic                         cam_valid_i,
   input  logic [PIX_PER_CLK*PIX_W-1:0] cam_r_i,
   input  logic [PIX_PER_CLK*PIX_W-1:0] cam_g_i,
   input  logic [PIX_PER_CLK*PIX_W-1:0] cam_b_i,
   input  logic                         trigger_capture_i,
   input  logic                         continuous_capture_i,
   input  logic                         rgb_gray_i,
   input  logic                         dma_init_done_i,
   input  logic                         dma_wready_i,
   output logic                         dma_wvalid_o,
   output logic                         dma_wlast_o,
   output logic [DMA_W-1:0]             dma_wdata_o,
   output dbg_count_t                   frames_per_second_o,
   output logic                         dbg_fifo_overflow_o,
   output dbg_count_t                   dbg_fifo_wcount_o,
   output dbg_count_t                   dbg_fifo_rcount_o
);

   if (PIX_PER_CLK != 2) begin : g_ppc_check
      $error("cam_frame_dma_top supports two pixels per clock only");
   end

   logic                         pix_valid, gray_sel;
   logic [PIX_PER_CLK*PIX_W-1:0] pix_r, pix_g, pix_b;
   logic [PIX_PER_CLK-1:0]       lane_valid;
   rgb_pix_t                     lane_pix [PIX_PER_CLK];

   cam_capture_ctrl #(
      .PCLK_RATE   (PCLK_RATE),
      .PIX_PER_CLK (PIX_PER_CLK)
   ) i_ctrl (
      .mipi_pclk            (mipi_pclk),
      .rst_n                (rst_n),
      .cam_vs_i             (cam_vs_i),
      .cam_valid_i          (cam_valid_i),
      .cam_r_i              (cam_r_i),
      .cam_g_i              (cam_g_i),
      .cam_b_i              (cam_b_i),
      .trigger_capture_i    (trigger_capture_i),
      .continuous_capture_i (continuous_capture_i),
      .rgb_gray_i           (rgb_gray_i),
      .pix_valid_o          (pix_valid),
      .pix_r_o              (pix_r),
      .pix_g_o              (pix_g),
      .pix_b_o              (pix_b),
      .gray_sel_o           (gray_sel),
      .frames_per_second_o  (frames_per_second_o)
   );

   for (genvar i = 0; i < PIX_PER_CLK; i++) begin : g_lane
      cam_pixel_lane i_lane (
         .mipi_pclk  (mipi_pclk),
         .rst_n      (rst_n),
         .valid_i    (pix_valid),
         .r_i        (pix_r[i*PIX_W +: PIX_W]),
         .g_i        (pix_g[i*PIX_W +: PIX_W]),
         .b_i        (pix_b[i*PIX_W +: PIX_W]),
         .gray_sel_i (gray_sel),
         .valid_o    (lane_valid[i]),
         .pix_o      (lane_pix[i])
      );
   end

   // Lanes run in lockstep, so their valids are identical
   cam_dma_writer #(
      .FIFO_DEPTH          (FIFO_DEPTH),
      .DMA_TRANSFER_LENGTH (DMA_TRANSFER_LENGTH),
      .PIX_PER_CLK         (PIX_PER_CLK)
   ) i_writer (
      .mipi_pclk           (mipi_pclk),
      .rst_n               (rst_n),
      .lane_valid_i        (&lane_valid),
      .lane0_pix_i         (lane_pix[0]),
      .lane1_pix_i         (lane_pix[1]),
      .dma_init_done_i     (dma_init_done_i),
      .dma_wready_i        (dma_wready_i),
      .dma_wvalid_o        (dma_wvalid_o),
      .dma_wlast_o         (dma_wlast_o),
      .dma_wdata_o         (dma_wdata_o),
      .dbg_fifo_overflow_o (dbg_fifo_overflow_o),
      .dbg_fifo_wcount_o   (dbg_fifo_wcount_o),
      .dbg_fifo_rcount_o   (dbg_fifo_rcount_o)
   );

endmodule : cam_frame_dma_top

// File: src/cam_dma_writer.sv
////////////////////////////////////////////////////////////////////////////
// Packs two lane pixels per DMA word and streams them out in bursts of
// DMA_TRANSFER_LENGTH beats. Each burst waits for a rising edge of the
// async init done input. The camera side is never stalled, so words that
// meet a full FIFO are lost and set the sticky overflow flag.
// Supports PIX_PER_CLK of 2 only.
////////////////////////////////////////////////////////////////////////////

module cam_dma_writer
   import cam_pix_pkg::*;
   import cam_ctrl_pkg::*;
#(
   parameter int FIFO_DEPTH          = 512,
   parameter int DMA_TRANSFER_LENGTH = 1920,
   parameter int PIX_PER_CLK         = 2
) (
   input  logic             mipi_pclk,
   input  logic             rst_n,
   input  logic             lane_valid_i,
   input  rgb_pix_t         lane0_pix_i,
   input  rgb_pix_t         lane1_pix_i,
   input  logic             dma_init_done_i,
   input  logic             dma_wready_i,
   output logic             dma_wvalid_o,
   output logic             dma_wlast_o,
   output logic [DMA_W-1:0] dma_wdata_o,
   output logic             dbg_fifo_overflow_o,
   output dbg_count_t       dbg_fifo_wcount_o,
   output dbg_count_t       dbg_fifo_rcount_o
);

   localparam int BW = (DMA_TRANSFER_LENGTH > 1) ? $clog2(DMA_TRANSFER_LENGTH) : 1;
   localparam logic [BW-1:0] LAST_BEAT = BW'(DMA_TRANSFER_LENGTH - 1);

   if (PIX_PER_CLK != 2) begin : g_ppc_check
      $error("cam_dma_writer packs exactly two pixels per word");
   end

   logic [DMA_W-1:0] pack_word;
   logic             fifo_empty, fifo_overflow;
   logic             init_s1, init_s2, init_s3;
   logic             burst_en, xfer;
   logic [BW-1:0]    beat_cnt;

   // Pad byte above each pixel
   assign pack_word = {8'h00, lane1_pix_i, 8'h00, lane0_pix_i};

   cam_sync_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) i_fifo (
      .mipi_pclk  (mipi_pclk),
      .rst_n      (rst_n),
      .wr_en_i    (lane_valid_i),
      .wdata_i    (pack_word),
      .rd_en_i    (xfer),
      .rdata_o    (dma_wdata_o),
      .empty_o    (fifo_empty),
      .overflow_o (fifo_overflow)
   );

   assign dma_wvalid_o = burst_en && !fifo_empty;
   assign xfer         = dma_wvalid_o && dma_wready_i;
   assign dma_wlast_o  = dma_wvalid_o && (beat_cnt == LAST_BEAT);

   always_ff @(posedge mipi_pclk) begin
      if (!rst_n) begin
         init_s1             <= 1'b0;
         init_s2             <= 1'b0;
         init_s3             <= 1'b0;
         burst_en            <= 1'b0;
         beat_cnt            <= '0;
         dbg_fifo_overflow_o <= 1'b0;
         dbg_fifo_wcount_o   <= '0;
         dbg_fifo_rcount_o   <= '0;
      end else begin
         init_s1 <= dma_init_done_i;
         init_s2 <= init_s1;
         init_s3 <= init_s2;

         // A new init done wins over closing the current burst
         if (init_s2 && !init_s3)      burst_en <= 1'b1;
         else if (xfer && dma_wlast_o) burst_en <= 1'b0;

         if (xfer) beat_cnt <= (beat_cnt == LAST_BEAT) ? '0 : beat_cnt + 1'b1;

         if (fifo_overflow) dbg_fifo_overflow_o <= 1'b1;
         if (lane_valid_i)  dbg_fifo_wcount_o   <= dbg_fifo_wcount_o + 1'b1;
         if (xfer)          dbg_fifo_rcount_o   <= dbg_fifo_rcount_o + 1'b1;
      end
   end

   // Every burst begins on beat zero
   a_burst_starts_at_zero: assert property (@(posedge mipi_pclk) disable iff (!rst_n)
      $rose(burst_en) |-> beat_cnt == '0);

   // Back-pressure holds the offered beat
   a_hold_on_stall: assert property (@(posedge mipi_pclk) disable iff (!rst_n)
      dma_wvalid_o && !dma_wready_i |=> dma_wvalid_o && $stable(dma_wdata_o));

endmodule : cam_dma_writer

// File: src/cam_sync_fifo.sv
////////////////////////////////////////////////////////////////////////////
// Single clock first-word-fall-through FIFO of DMA words. The head word
// is valid whenever empty_o is low. A write while full is dropped and
// overflow_o pulses for that cycle. The reader must not read when empty.
// FIFO_DEPTH need not be a power of two.
////////////////////////////////////////////////////////////////////////////

module cam_sync_fifo
   import cam_ctrl_pkg::*;
#(
   parameter int FIFO_DEPTH = 512
) (
   input  logic             mipi_pclk,
   input  logic             rst_n,
   input  logic             wr_en_i,
   input  logic [DMA_W-1:0] wdata_i,
   input  logic             rd_en_i,
   output logic [DMA_W-1:0] rdata_o,
   output logic             empty_o,
   output logic             overflow_o
);

   localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam int CW = $clog2(FIFO_DEPTH + 1);

   logic [DMA_W-1:0] mem [FIFO_DEPTH];
   logic [AW-1:0]    wr_ptr, rd_ptr;
   logic [CW-1:0]    count;
   logic             full, do_wr;

   function automatic logic [AW-1:0] ptr_next(input logic [AW-1:0] ptr);
      return (ptr == AW'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign full       = (count == CW'(FIFO_DEPTH));
   assign do_wr      = wr_en_i && !full;
   assign empty_o    = (count == '0);
   assign overflow_o = wr_en_i && full;

   // Head shown straight from the array
   assign rdata_o = mem[rd_ptr];

   always_ff @(posedge mipi_pclk) begin
      if (do_wr) mem[wr_ptr] <= wdata_i;
   end

   always_ff @(posedge mipi_pclk) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr)   wr_ptr <= ptr_next(wr_ptr);
         if (rd_en_i) rd_ptr <= ptr_next(rd_ptr);
         count <= count + CW'(do_wr) - CW'(rd_en_i);
      end
   end

   a_no_read_empty: assert property (@(posedge mipi_pclk) disable iff (!rst_n)
      rd_en_i |-> !empty_o);

endmodule : cam_sync_fifo

// File: src/cam_pixel_lane.sv
////////////////////////////////////////////////////////////////////////////
// One pixel lane. Passes RGB through or replaces it with the weighted
// gray value in all three channels. One cycle of latency. The pixel
// register only loads on valid and holds otherwise.
////////////////////////////////////////////////////////////////////////////

module cam_pixel_lane
   import cam_pix_pkg::*;
(
   input  logic             mipi_pclk,
   input  logic             rst_n,
   input  logic             valid_i,
   input  logic [PIX_W-1:0] r_i,
   input  logic [PIX_W-1:0] g_i,
   input  logic [PIX_W-1:0] b_i,
   input  logic             gray_sel_i,
   output logic             valid_o,
   output rgb_pix_t         pix_o
);

   logic [2*PIX_W-1:0] gray_sum;
   logic [PIX_W-1:0]   gray;

   // Weights sum to 256, so the top byte is the gray level
   assign gray_sum = GRAY_COEF_R * r_i + GRAY_COEF_G * g_i + GRAY_COEF_B * b_i;
   assign gray     = gray_sum[2*PIX_W-1:PIX_W];

   always_ff @(posedge mipi_pclk) begin
      if (valid_i) begin
         if (gray_sel_i) begin
            pix_o <= '{b: gray, g: gray, r: gray};
         end else begin
            pix_o <= '{b: b_i, g: g_i, r: r_i};
         end
      end
   end

   always_ff @(posedge mipi_pclk) begin
      if (!rst_n) valid_o <= 1'b0;
      else        valid_o <= valid_i;
   end

endmodule : cam_pixel_lane

// File: src/cam_capture_ctrl.sv
////////////////////////////////////////////////////////////////////////////
// Registers the RGB stream and opens it for one frame or for all frames.
// Capture starts and stops only on a falling edge of vsync. Trigger,
// continuous and gray select are async and pass a two flop synchronizer.
// Continuous capture is sticky until reset. The fps counter assumes the
// frame rate is above 1 Hz and PCLK_RATE matches the real clock.
////////////////////////////////////////////////////////////////////////////

module cam_capture_ctrl
   import cam_pix_pkg::*;
   import cam_ctrl_pkg::*;
#(
   parameter int PCLK_RATE   = 75000000,
   parameter int PIX_PER_CLK = 2
) (
   input  logic                         mipi_pclk,
   input  logic                         rst_n,
   input  logic                         cam_vs_i,
   input  logic                         cam_valid_i,
   input  logic [PIX_PER_CLK*PIX_W-1:0] cam_r_i,
   input  logic [PIX_PER_CLK*PIX_W-1:0] cam_g_i,
   input  logic [PIX_PER_CLK*PIX_W-1:0] cam_b_i,
   input  logic                         trigger_capture_i,
   input  logic                         continuous_capture_i,
   input  logic                         rgb_gray_i,
   output logic                         pix_valid_o,
   output logic [PIX_PER_CLK*PIX_W-1:0] pix_r_o,
   output logic [PIX_PER_CLK*PIX_W-1:0] pix_g_o,
   output logic [PIX_PER_CLK*PIX_W-1:0] pix_b_o,
   output logic                         gray_sel_o,
   output dbg_count_t                   frames_per_second_o
);

   capture_state_e state;
   logic           vs_q, vs_q2, vs_fall;
   logic           trig_s1, trig_s2, trig_s3, trig_rise, trig_pend;
   logic           cont_s1, cont_s2, cont_hold;
   logic           gray_s1;
   dbg_count_t     timer, frame_cnt;

   assign vs_fall   = vs_q2 && !vs_q;
   assign trig_rise = trig_s2 && !trig_s3;

   // Pixel payload, one cycle
   always_ff @(posedge mipi_pclk) begin
      pix_r_o <= cam_r_i;
      pix_g_o <= cam_g_i;
      pix_b_o <= cam_b_i;
   end

   always_ff @(posedge mipi_pclk) begin
      if (!rst_n) begin
         vs_q        <= 1'b0;
         vs_q2       <= 1'b0;
         trig_s1     <= 1'b0;
         trig_s2     <= 1'b0;
         trig_s3     <= 1'b0;
         trig_pend   <= 1'b0;
         cont_s1     <= 1'b0;
         cont_s2     <= 1'b0;
         cont_hold   <= 1'b0;
         gray_s1     <= 1'b0;
         gray_sel_o  <= 1'b0;
         pix_valid_o <= 1'b0;
         state       <= CAP_IDLE;
      end else begin
         vs_q        <= cam_vs_i;
         vs_q2       <= vs_q;
         trig_s1     <= trigger_capture_i;
         trig_s2     <= trig_s1;
         trig_s3     <= trig_s2;
         cont_s1     <= continuous_capture_i;
         cont_s2     <= cont_s1;
         cont_hold   <= cont_hold || cont_s2;
         gray_s1     <= rgb_gray_i;
         gray_sel_o  <= gray_s1;
         pix_valid_o <= cam_valid_i && (state inside {CAP_FRAME, CAP_STREAM});

         // A trigger during a frame re-arms for the one after it
         if (state == CAP_FRAME && vs_fall) begin
            trig_pend <= 1'b0;
         end else if (state == CAP_FRAME && trig_rise) begin
            trig_pend <= 1'b1;
         end

         case (state)
            CAP_IDLE: begin
               if (trig_rise || cont_hold) state <= CAP_ARMED;
            end
            CAP_ARMED: begin
               if (vs_fall) state <= cont_hold ? CAP_STREAM : CAP_FRAME;
            end
            CAP_FRAME: begin
               if (vs_fall) state <= (trig_pend || trig_rise) ? CAP_ARMED : CAP_IDLE;
            end
            default: state <= CAP_STREAM;
         endcase
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Frames per second over a window of PCLK_RATE+1 clocks
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge mipi_pclk) begin
      if (!rst_n) begin
         timer               <= '0;
         frame_cnt           <= '0;
         frames_per_second_o <= '0;
      end else if (timer == dbg_count_t'(PCLK_RATE)) begin
         timer               <= '0;
         frame_cnt           <= '0;
         frames_per_second_o <= frame_cnt;
      end else begin
         timer <= timer + 1'b1;
         if (vs_fall) frame_cnt <= frame_cnt + 1'b1;
      end
   end

   // Once armed, capture opens and closes only on a falling vsync
   a_state_on_vs_fall: assert property (@(posedge mipi_pclk) disable iff (!rst_n)
      state != CAP_IDLE && !vs_fall |=> $stable(state));

endmodule : cam_capture_ctrl

// File: src/cam_ctrl_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Control side definitions: capture FSM states, the DMA word width and
// the width of the debug and frame rate counters. Counters are 32 bits
// and wrap silently.
////////////////////////////////////////////////////////////////////////////

package cam_ctrl_pkg;

   // Capture FSM states
   typedef enum logic [1:0] {
      CAP_IDLE   = 2'd0,
      CAP_ARMED  = 2'd1,
      CAP_FRAME  = 2'd2,
      CAP_STREAM = 2'd3
   } capture_state_e;

   // DMA data bus width
   parameter int DMA_W = 64;

   // Debug and fps counters
   typedef logic [31:0] dbg_count_t;

endpackage : cam_ctrl_pkg

// File: src/cam_pix_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Pixel format definitions shared by the capture controller, the pixel
// lanes and the DMA writer. One channel is PIX_W bits wide and a packed
// pixel holds blue in the top byte. Gray uses integer BT.601 weights that
// sum to 256, so the result is the weighted sum shifted right by PIX_W.
////////////////////////////////////////////////////////////////////////////

package cam_pix_pkg;

   // Bits per color channel
   parameter int PIX_W = 8;

   // One pixel, blue most significant
   typedef struct packed {
      logic [PIX_W-1:0] b;
      logic [PIX_W-1:0] g;
      logic [PIX_W-1:0] r;
   } rgb_pix_t;

   // Grayscale weights, sum is 256
   parameter logic [PIX_W-1:0] GRAY_COEF_R = 8'd77;
   parameter logic [PIX_W-1:0] GRAY_COEF_G = 8'd150;
   parameter logic [PIX_W-1:0] GRAY_COEF_B = 8'd29;

endpackage : cam_pix_pkg
